// File: logic/sr_band_oscillator.sv
// Driven rotating oscillator
`timescale 1ns/1ps

module sr_band_oscillator #(
    parameter logic signed [sr_fixed_pkg::WIDTH-1:0] DEFAULT_OMEGA_DT = 18'sd196,
    parameter bit                                    ENABLE_DRIFT     = 1'b1
) (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  clk_en,
    input  logic signed [sr_fixed_pkg::WIDTH-1:0] omega_dt_ext,
    input  logic signed [sr_fixed_pkg::WIDTH-1:0] field,
    sr_phase_if.osc                               phase
);

    localparam int W = sr_fixed_pkg::WIDTH;
    localparam int FRAC = sr_fixed_pkg::FRAC;

    // State registers, Q14
    logic signed [W-1:0] x_q;
    logic signed [W-1:0] y_q;

    // Step, products and next state
    logic signed [W-1:0]                        omega;
    logic signed [sr_fixed_pkg::PROD_WIDTH-1:0] prod_wy;
    logic signed [sr_fixed_pkg::PROD_WIDTH-1:0] prod_wx;
    logic signed [W-1:0]                        x_next;
    logic signed [W-1:0]                        y_next;

    // ---------------------------------------------------------------------------
    // Rotation step
    // ---------------------------------------------------------------------------

    // External drift wins only when enabled and nonzero
    assign omega = (ENABLE_DRIFT && (omega_dt_ext != '0)) ? omega_dt_ext : DEFAULT_OMEGA_DT;

    // Semi-implicit update, x first
    assign prod_wy = omega * y_q;
    // Field drive lands on x only
    assign x_next  = x_q - prod_wy[FRAC +: W] + field;

    // y rotates against the already updated x
    assign prod_wx = omega * x_next;
    assign y_next  = y_q + prod_wx[FRAC +: W];

    // ---------------------------------------------------------------------------
    // State
    // ---------------------------------------------------------------------------

    // Start on the unit circle at phase zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            x_q <= sr_fixed_pkg::ONE;
            y_q <= '0;
        end else if (clk_en) begin
            x_q <= x_next;
            y_q <= y_next;
        end
    end

    assign phase.f_x = x_q;
    assign phase.f_y = y_q;

endmodule

// File: logic/sr_band_pkg.sv
// Harmonic band constants
package sr_band_pkg;

    // ---------------------------------------------------------------------------
    // Harmonic set
    // ---------------------------------------------------------------------------

    // Schumann modes modelled by the bank
    localparam int NUM_HARMONICS = 5;

    // Rotation step per enabled clock, Q14 radians
    // Modes at roughly 7.6, 13.75, 20, 25 and 32 Hz with a 4 kHz update
    localparam logic signed [sr_fixed_pkg::WIDTH-1:0]
        DEFAULT_OMEGA_DT [NUM_HARMONICS] = '{
            18'sd196, 18'sd354, 18'sd514, 18'sd643, 18'sd823
        };

    // ---------------------------------------------------------------------------
    // Gate and coherence thresholds, all Q14
    // ---------------------------------------------------------------------------

    // Beta band counts as quiet below 0.9375
    localparam logic signed [sr_fixed_pkg::WIDTH-1:0] BETA_QUIET_THRESHOLD = 18'sd15360;

    // High phase locking above 0.75
    localparam logic signed [sr_fixed_pkg::WIDTH-1:0] COHERENCE_THRESHOLD = 18'sd12288;

    // Gain ramp floor, 0.5
    localparam logic signed [sr_fixed_pkg::WIDTH-1:0] COH_LOW = 18'sd8192;

    // Gain ramp ceiling, 1.0
    localparam logic signed [sr_fixed_pkg::WIDTH-1:0] COH_HIGH = 18'sd16384;

endpackage

// File: logic/sr_beta_gate.sv
// Beta quiet gate
`timescale 1ns/1ps

module sr_beta_gate (
    input  logic signed [sr_fixed_pkg::WIDTH-1:0] beta_amplitude,
    output logic                                  beta_quiet,
    output logic signed [sr_fixed_pkg::WIDTH-1:0] beta_factor
);

    localparam int W = sr_fixed_pkg::WIDTH;

    // One spare bit so a negative amplitude cannot wrap the margin
    localparam int DW = W + 1;

    // Margin below threshold and its scaled form
    logic signed [DW-1:0] diff;
    logic signed [DW:0]   factor_sum;

    // ---------------------------------------------------------------------------
    // Quiet decision
    // ---------------------------------------------------------------------------

    // Strictly below threshold
    assign beta_quiet = beta_amplitude < sr_band_pkg::BETA_QUIET_THRESHOLD;

    // ---------------------------------------------------------------------------
    // Continuous factor
    // ---------------------------------------------------------------------------

    always_comb begin
        diff = '0;
        if (beta_quiet) begin
            diff = DW'(sr_band_pkg::BETA_QUIET_THRESHOLD) - DW'(beta_amplitude);
        end
        // ONE / threshold is close to 1 + 1/16
        factor_sum = (DW + 1)'(diff) + (DW + 1)'(diff >>> 4);
        // Clamp at unity
        if (factor_sum > (DW + 1)'(sr_fixed_pkg::ONE)) begin
            beta_factor = sr_fixed_pkg::ONE;
        end else begin
            beta_factor = factor_sum[W-1:0];
        end
    end

endmodule

// File: logic/sr_coherence_gain.sv
// Harmonic coherence and gain
`timescale 1ns/1ps

module sr_coherence_gain (
    input  logic                                  clk,
    input  logic                                  arst_n,
    sr_phase_if.coh                               phase,
    input  logic                                  beta_quiet,
    input  logic signed [sr_fixed_pkg::WIDTH-1:0] beta_factor,
    output logic signed [sr_fixed_pkg::WIDTH-1:0] coherence,
    output logic signed [sr_fixed_pkg::WIDTH-1:0] gain,
    output logic                                  high_coherence,
    output logic                                  sie
);

    localparam int W = sr_fixed_pkg::WIDTH;
    localparam int FRAC = sr_fixed_pkg::FRAC;
    localparam int PW = sr_fixed_pkg::PROD_WIDTH;

    // Dot product needs one carry bit above a single product
    localparam int DW = PW + 1;

    logic signed [PW-1:0]      prod_x;
    logic signed [PW-1:0]      prod_y;
    logic signed [DW-1:0]      dot;
    logic signed [DW-FRAC-1:0] dot_q;
    logic signed [W-1:0]       coh_next;
    logic                      mask_next;
    logic signed [W-1:0]       ramp;
    logic signed [PW-1:0]      gain_prod;

    // ---------------------------------------------------------------------------
    // Phase alignment
    // ---------------------------------------------------------------------------

    // Cosine of the phase difference when both sit near unit amplitude
    assign prod_x = phase.target_x * phase.f_x;
    assign prod_y = phase.target_y * phase.f_y;
    assign dot    = DW'(prod_x) + DW'(prod_y);
    assign dot_q  = dot[DW-1:FRAC];

    // Magnitude first, then truncate to the sample word
    assign coh_next  = dot_q[DW-FRAC-1] ? W'(-dot_q) : dot_q[W-1:0];
    assign mask_next = coh_next > sr_band_pkg::COHERENCE_THRESHOLD;

    // ---------------------------------------------------------------------------
    // Gain
    // ---------------------------------------------------------------------------

    // Linear ramp from COH_LOW to COH_HIGH, slope two
    always_comb begin
        if (coh_next < sr_band_pkg::COH_LOW) begin
            ramp = '0;
        end else if (coh_next >= sr_band_pkg::COH_HIGH) begin
            ramp = sr_fixed_pkg::ONE;
        end else begin
            ramp = (coh_next - sr_band_pkg::COH_LOW) <<< 1;
        end
    end

    // Q14 times Q14, back to Q14
    assign gain_prod = ramp * beta_factor;

    // Results registered on every clock, not only on clk_en
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            coherence      <= '0;
            gain           <= '0;
            high_coherence <= 1'b0;
            sie            <= 1'b0;
        end else begin
            coherence      <= coh_next;
            gain           <= gain_prod[FRAC +: W];
            high_coherence <= mask_next;
            // Locked and beta quiet
            sie            <= mask_next && beta_quiet;
        end
    end

endmodule

// File: logic/sr_fixed_pkg.sv
// Fixed-point number format
package sr_fixed_pkg;

    // ---------------------------------------------------------------------------
    // Sample format
    // ---------------------------------------------------------------------------

    // Signed sample word, Q3.14 plus sign
    localparam int WIDTH = 18;

    // Fraction bits of every oscillator, target and gain word
    localparam int FRAC = 14;

    // Unity gain / unit amplitude
    localparam logic signed [WIDTH-1:0] ONE = 18'sd16384;

    // ---------------------------------------------------------------------------
    // Products
    // ---------------------------------------------------------------------------

    // Full product of two samples, Q28 before the shift back
    localparam int PROD_WIDTH = 2 * WIDTH;

    // Products are rescaled with an arithmetic shift by FRAC
    // and truncated to WIDTH, so results wrap on overflow
    // rather than saturate

endpackage

// File: logic/sr_harmonic_bank.sv
// Schumann harmonic bank
`timescale 1ns/1ps

module sr_harmonic_bank #(
    parameter bit ENABLE_DRIFT = 1'b1
) (
    input  logic clk,
    input  logic arst_n,
    input  logic clk_en,

    // Per-harmonic inputs, harmonic 0 in the low word
    input  logic signed [sr_band_pkg::NUM_HARMONICS*sr_fixed_pkg::WIDTH-1:0] omega_dt_packed,
    input  logic signed [sr_band_pkg::NUM_HARMONICS*sr_fixed_pkg::WIDTH-1:0] sr_field_packed,
    input  logic signed [sr_band_pkg::NUM_HARMONICS*sr_fixed_pkg::WIDTH-1:0] target_x_packed,
    input  logic signed [sr_band_pkg::NUM_HARMONICS*sr_fixed_pkg::WIDTH-1:0] target_y_packed,

    // Shared beta band level
    input  logic signed [sr_fixed_pkg::WIDTH-1:0] beta_amplitude,

    // Per-harmonic results
    output logic signed [sr_band_pkg::NUM_HARMONICS*sr_fixed_pkg::WIDTH-1:0] f_x_packed,
    output logic signed [sr_band_pkg::NUM_HARMONICS*sr_fixed_pkg::WIDTH-1:0] f_y_packed,
    output logic signed [sr_band_pkg::NUM_HARMONICS*sr_fixed_pkg::WIDTH-1:0] coherence_packed,
    output logic signed [sr_band_pkg::NUM_HARMONICS*sr_fixed_pkg::WIDTH-1:0] gain_packed,
    output logic        [sr_band_pkg::NUM_HARMONICS-1:0]                     sie_per_harmonic,
    output logic        [sr_band_pkg::NUM_HARMONICS-1:0]                     coherence_mask,

    // Aggregates
    output logic sie_active_any,
    output logic beta_quiet
);

    localparam int W = sr_fixed_pkg::WIDTH;
    localparam int NH = sr_band_pkg::NUM_HARMONICS;

    logic signed [W-1:0] beta_factor;

    // ---------------------------------------------------------------------------
    // Shared gate
    // ---------------------------------------------------------------------------

    sr_beta_gate i_beta_gate (
        .beta_amplitude (beta_amplitude),
        .beta_quiet     (beta_quiet),
        .beta_factor    (beta_factor)
    );

    // ---------------------------------------------------------------------------
    // Harmonics
    // ---------------------------------------------------------------------------

    for (genvar h = 0; h < NH; h++) begin : g_harmonic
        sr_phase_if phase_bus ();

        // Band target for this mode
        assign phase_bus.target_x = target_x_packed[h*W +: W];
        assign phase_bus.target_y = target_y_packed[h*W +: W];

        // Each mode starts from its own package step
        sr_band_oscillator #(
            .DEFAULT_OMEGA_DT (sr_band_pkg::DEFAULT_OMEGA_DT[h]),
            .ENABLE_DRIFT     (ENABLE_DRIFT)
        ) i_osc (
            .clk          (clk),
            .arst_n       (arst_n),
            .clk_en       (clk_en),
            .omega_dt_ext (omega_dt_packed[h*W +: W]),
            .field        (sr_field_packed[h*W +: W]),
            .phase        (phase_bus)
        );

        sr_coherence_gain i_coh (
            .clk            (clk),
            .arst_n         (arst_n),
            .phase          (phase_bus),
            .beta_quiet     (beta_quiet),
            .beta_factor    (beta_factor),
            .coherence      (coherence_packed[h*W +: W]),
            .gain           (gain_packed[h*W +: W]),
            .high_coherence (coherence_mask[h]),
            .sie            (sie_per_harmonic[h])
        );

        // State straight out to the packed ports
        assign f_x_packed[h*W +: W] = phase_bus.f_x;
        assign f_y_packed[h*W +: W] = phase_bus.f_y;
    end

    // Any harmonic in SIE, from registered bits
    assign sie_active_any = |sie_per_harmonic;

endmodule

// File: logic/sr_phase_if.sv
// Harmonic phase interface
`timescale 1ns/1ps

interface sr_phase_if;

    // Oscillator state of one harmonic, Q14
    logic signed [sr_fixed_pkg::WIDTH-1:0] f_x;
    logic signed [sr_fixed_pkg::WIDTH-1:0] f_y;

    // Phase of the matching brain band, Q14
    logic signed [sr_fixed_pkg::WIDTH-1:0] target_x;
    logic signed [sr_fixed_pkg::WIDTH-1:0] target_y;

    // Oscillator side
    modport osc (output f_x, output f_y);

    // Band target side, driven from the top level
    modport band (output target_x, output target_y);

    // Coherence stage sees both phases
    modport coh (input f_x, input f_y, input target_x, input target_y);

endinterface

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the harmonic bank testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
BIN=obj_dir/sr_harmonic_bank_sim

verilator --binary --timing --assert -Wno-fatal \
    --top-module sr_harmonic_bank_tb -o sr_harmonic_bank_sim \
    -f sr_harmonic_bank.f > "$BUILD_LOG" 2>&1 \
    || { echo "Verilator build failed, see $BUILD_LOG"; exit 1; }

"$BIN" > "$SIM_LOG" 2>&1 \
    || { echo "Simulation aborted, see $SIM_LOG"; exit 1; }

grep -q ">>> FAIL" "$SIM_LOG" \
    && { echo "Simulation reported failure, see $SIM_LOG"; exit 1; } \
    || { echo "Simulation passed, see $SIM_LOG"; exit 0; }

// File: sr_harmonic_bank.f
logic/sr_fixed_pkg.sv
logic/sr_band_pkg.sv
logic/sr_phase_if.sv
logic/sr_band_oscillator.sv
logic/sr_beta_gate.sv
logic/sr_coherence_gain.sv
logic/sr_harmonic_bank.sv
tb/sr_bank_checker.sv
tb/sr_bank_props.sv
tb/sr_harmonic_bank_tb.sv

// File: tb/sr_bank_checker.sv
// Harmonic bank reference model
`timescale 1ns/1ps

module sr_bank_checker #(
    parameter bit ENABLE_DRIFT = 1'b1
) (
    input  logic                                                    clk,
    input  logic                                                    arst_n,
    input  logic                                                    clk_en,
    input  logic [sr_band_pkg::NUM_HARMONICS*sr_fixed_pkg::WIDTH-1:0] omega_dt_packed,
    input  logic [sr_band_pkg::NUM_HARMONICS*sr_fixed_pkg::WIDTH-1:0] sr_field_packed,
    input  logic [sr_band_pkg::NUM_HARMONICS*sr_fixed_pkg::WIDTH-1:0] target_x_packed,
    input  logic [sr_band_pkg::NUM_HARMONICS*sr_fixed_pkg::WIDTH-1:0] target_y_packed,
    input  logic signed [sr_fixed_pkg::WIDTH-1:0]                   beta_amplitude,
    input  logic [sr_band_pkg::NUM_HARMONICS*sr_fixed_pkg::WIDTH-1:0] f_x_packed,
    input  logic [sr_band_pkg::NUM_HARMONICS*sr_fixed_pkg::WIDTH-1:0] f_y_packed,
    input  logic [sr_band_pkg::NUM_HARMONICS*sr_fixed_pkg::WIDTH-1:0] coherence_packed,
    input  logic [sr_band_pkg::NUM_HARMONICS*sr_fixed_pkg::WIDTH-1:0] gain_packed,
    input  logic [sr_band_pkg::NUM_HARMONICS-1:0]                   sie_per_harmonic,
    input  logic [sr_band_pkg::NUM_HARMONICS-1:0]                   coherence_mask,
    input  logic                                                    sie_active_any,
    input  logic                                                    beta_quiet,
    input  logic [95:0]                                             test_name,
    output int                                                      error_count,
    output int                                                      check_count
);

    localparam int W = sr_fixed_pkg::WIDTH;
    localparam int FRAC = sr_fixed_pkg::FRAC;
    localparam int NH = sr_band_pkg::NUM_HARMONICS;
    localparam longint ONE = sr_fixed_pkg::ONE;

    int errors = 0;
    int checks = 0;

    // ---------------------------------------------------------------------------
    // Model state and the inputs of the previous cycle
    // ---------------------------------------------------------------------------

    longint              mx [NH];
    longint              my [NH];
    logic                p_rstn = 1'b0;
    logic                p_en = 1'b0;
    logic [NH*W-1:0]     p_omega = '0;
    logic [NH*W-1:0]     p_field = '0;
    logic [NH*W-1:0]     p_tx = '0;
    logic [NH*W-1:0]     p_ty = '0;
    logic signed [W-1:0] p_beta = '0;
    logic [95:0]         p_name = '0;

    assign error_count = errors;
    assign check_count = checks;

    // Signed word h of a packed bus, X kept
    function automatic logic signed [63:0] word(input logic [NH*W-1:0] bus, input int h);
        logic signed [W-1:0] t;
        t = bus[h*W +: W];
        return t;
    endfunction

    // Truncate to the sample width
    function automatic longint wrap(input longint v);
        logic signed [W-1:0] t;
        t = v[W-1:0];
        return t;
    endfunction

    // Margin below the quiet threshold times 1 + 1/16, at most unity
    function automatic longint factor_of(input longint beta);
        longint diff;
        longint f;
        diff = 0;
        if (beta < sr_band_pkg::BETA_QUIET_THRESHOLD) begin
            diff = sr_band_pkg::BETA_QUIET_THRESHOLD - beta;
        end
        f = diff + (diff >>> 4);
        return (f > ONE) ? ONE : f;
    endfunction

    task automatic compare(input string what, input int h,
                           input logic signed [63:0] exp, input logic signed [63:0] act);
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s %s[%0d] expected %0d actual %0d", p_name, what, h, exp, act);
        end
    endtask

    // ---------------------------------------------------------------------------
    // Per-cycle comparison at the falling edge
    // ---------------------------------------------------------------------------

    always @(negedge clk) begin
        longint        bf;
        longint        q;
        longint        coh;
        longint        ramp;
        longint        g;
        longint        omega;
        longint        nx;
        logic          e_mask;
        logic [NH-1:0] e_sie;
        checks++;
        e_sie = '0;
        bf = factor_of(p_beta);
        for (int h = 0; h < NH; h++) begin
            if (!p_rstn || !arst_n) begin
                mx[h]  = ONE;
                my[h]  = 0;
                coh    = 0;
                g      = 0;
                e_mask = 1'b0;
            end else begin
                // Results come from last cycle's targets and the pre-step state
                q = (word(p_tx, h) * mx[h] + word(p_ty, h) * my[h]) >>> FRAC;
                coh = wrap((q < 0) ? -q : q);
                e_mask = coh > sr_band_pkg::COHERENCE_THRESHOLD;
                e_sie[h] = e_mask && (p_beta < sr_band_pkg::BETA_QUIET_THRESHOLD);
                if (coh < sr_band_pkg::COH_LOW) begin
                    ramp = 0;
                end else if (coh >= sr_band_pkg::COH_HIGH) begin
                    ramp = ONE;
                end else begin
                    ramp = 2 * (coh - sr_band_pkg::COH_LOW);
                end
                g = wrap((ramp * bf) >>> FRAC);
                if (p_en) begin
                    omega = sr_band_pkg::DEFAULT_OMEGA_DT[h];
                    if (ENABLE_DRIFT && word(p_omega, h) != 0) begin
                        omega = word(p_omega, h);
                    end
                    // x first with the drive, then y from the new x
                    nx = wrap(mx[h] - ((omega * my[h]) >>> FRAC) + word(p_field, h));
                    my[h] = wrap(my[h] + ((omega * nx) >>> FRAC));
                    mx[h] = nx;
                end
            end
            compare("coherence", h, coh, word(coherence_packed, h));
            compare("gain", h, g, word(gain_packed, h));
            compare("mask", h, e_mask, coherence_mask[h]);
            compare("sie", h, e_sie[h], sie_per_harmonic[h]);
            compare("f_x", h, mx[h], word(f_x_packed, h));
            compare("f_y", h, my[h], word(f_y_packed, h));
        end
        compare("sie_any", 0, |e_sie, sie_active_any);
        compare("beta_quiet", 0, beta_amplitude < sr_band_pkg::BETA_QUIET_THRESHOLD, beta_quiet);
        p_rstn  = arst_n;
        p_en    = clk_en;
        p_omega = omega_dt_packed;
        p_field = sr_field_packed;
        p_tx    = target_x_packed;
        p_ty    = target_y_packed;
        p_beta  = beta_amplitude;
        p_name  = test_name;
    end

endmodule

// File: tb/sr_bank_props.sv
// Harmonic bank assertions
`timescale 1ns/1ps

module sr_bank_props (
    input logic                                                    clk,
    input logic                                                    arst_n,
    input logic [sr_band_pkg::NUM_HARMONICS*sr_fixed_pkg::WIDTH-1:0] coherence_packed,
    input logic [sr_band_pkg::NUM_HARMONICS*sr_fixed_pkg::WIDTH-1:0] gain_packed,
    input logic [sr_band_pkg::NUM_HARMONICS-1:0]                   coherence_mask,
    input logic [sr_band_pkg::NUM_HARMONICS-1:0]                   sie_per_harmonic,
    input logic                                                    sie_active_any,
    input logic                                                    beta_quiet
);

    localparam int W = sr_fixed_pkg::WIDTH;

    // Any-SIE is the plain OR of the harmonic bits
    a_sie_any: assert property (@(posedge clk) disable iff (!arst_n)
        sie_active_any == |sie_per_harmonic)
        else $error("sie_active_any differs from the OR of sie_per_harmonic");

    for (genvar h = 0; h < sr_band_pkg::NUM_HARMONICS; h++) begin : g_harmonic
        a_sie_mask: assert property (@(posedge clk) disable iff (!arst_n)
            sie_per_harmonic[h] |-> coherence_mask[h])
            else $error("SIE set without its mask bit on harmonic %0d", h);

        a_mask_coh: assert property (@(posedge clk) disable iff (!arst_n)
            coherence_mask[h] |->
                $signed(coherence_packed[h*W +: W]) > sr_band_pkg::COHERENCE_THRESHOLD)
            else $error("Mask bit set at or below threshold on harmonic %0d", h);

        // Loud beta leaves no gain on the next cycle
        a_gain_loud: assert property (@(posedge clk) disable iff (!arst_n)
            !beta_quiet |=> gain_packed[h*W +: W] == '0)
            else $error("Gain nonzero after loud beta on harmonic %0d", h);
    end

endmodule

// File: tb/sr_harmonic_bank_tb.sv
// Harmonic bank testbench
`timescale 1ns/1ps

module sr_harmonic_bank_tb;

    localparam int W = sr_fixed_pkg::WIDTH;
    localparam int NH = sr_band_pkg::NUM_HARMONICS;
    localparam int BW = NH * W;
    localparam int CHECK_TIMEOUT = 50;

    // One row of the stimulus table
    typedef struct packed {
        logic [95:0]   name;
        logic          en;
        logic [BW-1:0] omega;
        logic [BW-1:0] field;
        logic [BW-1:0] tx;
        logic [BW-1:0] ty;
        logic [W-1:0]  beta;
        int            cycles;
    } row_t;

    logic                 clk = 1'b0;
    logic                 arst_n;
    logic                 clk_en;
    logic signed [BW-1:0] omega_dt_packed;
    logic signed [BW-1:0] sr_field_packed;
    logic signed [BW-1:0] target_x_packed;
    logic signed [BW-1:0] target_y_packed;
    logic signed [W-1:0]  beta_amplitude;
    logic signed [BW-1:0] f_x_packed;
    logic signed [BW-1:0] f_y_packed;
    logic signed [BW-1:0] coherence_packed;
    logic signed [BW-1:0] gain_packed;
    logic [NH-1:0]        sie_per_harmonic;
    logic [NH-1:0]        coherence_mask;
    logic                 sie_active_any;
    logic                 beta_quiet;
    logic [95:0]          test_name;
    int                   error_count;
    int                   check_count;
    int                   timeouts = 0;
    logic [31:0]          rng_state = 32'hbf47_37f2;
    row_t                 rows[$];

    // 8 ns period
    always #4 clk = ~clk;

    sr_harmonic_bank #(.ENABLE_DRIFT(1'b1)) i_dut (.*);

    sr_bank_checker #(.ENABLE_DRIFT(1'b1)) i_checker (.*);

    bind sr_harmonic_bank sr_bank_props i_props (
        .clk              (clk),
        .arst_n           (arst_n),
        .coherence_packed (coherence_packed),
        .gain_packed      (gain_packed),
        .coherence_mask   (coherence_mask),
        .sie_per_harmonic (sie_per_harmonic),
        .sie_active_any   (sie_active_any),
        .beta_quiet       (beta_quiet)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // Harmonic 0 in the low word
    function automatic logic [BW-1:0] pack_bus(input int a, input int b, input int c,
                                               input int d, input int e);
        return {W'(e), W'(d), W'(c), W'(b), W'(a)};
    endfunction

    // Targets spread over -ONE to +ONE
    task automatic random_bus(output logic [BW-1:0] bus);
        for (int h = 0; h < NH; h++) begin
            rng_state = xorshift32(rng_state);
            bus[h*W +: W] = W'(int'(rng_state % 32'd32769) - 16384);
        end
    endtask

    task automatic add_row(
        input logic [95:0]   name,
        input logic          en,
        input logic [BW-1:0] omega,
        input logic [BW-1:0] field,
        input logic [BW-1:0] tx,
        input logic [BW-1:0] ty,
        input logic [W-1:0]  beta,
        input int            cycles
    );
        rows.push_back('{name, en, omega, field, tx, ty, beta, cycles});
    endtask

    task automatic build_table();
        logic [BW-1:0] ones;
        logic [BW-1:0] rx;
        logic [BW-1:0] ry;
        ones = pack_bus(16384, 16384, 16384, 16384, 16384);
        add_row("idle", 1'b0, '0, '0, '0, '0, '0, 3);
        // Beta sweep with every harmonic fully aligned
        add_row("beta_zero", 1'b0, '0, '0, ones, '0, 18'sd0, 2);
        add_row("beta_mid", 1'b0, '0, '0, ones, '0, 18'sd7680, 2);
        add_row("beta_below", 1'b0, '0, '0, ones, '0, 18'sd15359, 2);
        add_row("beta_at", 1'b0, '0, '0, ones, '0, 18'sd15360, 2);
        add_row("beta_above", 1'b0, '0, '0, ones, '0, 18'sd20000, 2);
        add_row("beta_clamp", 1'b0, '0, '0, ones, '0, -18'sd2000, 2);
        // State sits at (ONE, 0), so coherence follows target_x
        add_row("coh_edges", 1'b0, '0, '0, pack_bus(8191, 8192, 12288, 12289, 16383), '0, '0, 2);
        add_row("coh_high", 1'b0, '0, '0, pack_bus(16384, 20000, 9000, 14000, 12000), '0, '0, 2);
        add_row("coh_negative", 1'b0, '0, '0,
                pack_bus(-8191, -12289, -16384, -10000, -20000), '0, '0, 2);
        for (int i = 0; i < 3; i++) begin
            random_bus(rx);
            random_bus(ry);
            add_row("coh_random", 1'b0, '0, '0, rx, ry, '0, 2);
        end
        // Default steps only
        random_bus(rx);
        random_bus(ry);
        add_row("rotate", 1'b1, '0, '0, rx, ry, 18'sd3000, 24);
        add_row("rotate_hold", 1'b0, '0, '0, ry, rx, '0, 3);
        // External steps on some modes, drive on most
        random_bus(rx);
        random_bus(ry);
        add_row("drift", 1'b1, pack_bus(300, 0, 1000, 0, -500), pack_bus(40, 0, -25, 0, 12),
                rx, ry, '0, 16);
        add_row("drift_hold", 1'b0, '0, '0, ry, rx, 18'sd5000, 4);
    endtask

    // Inputs change on the rising edge, then the row is held
    task automatic apply_row(input row_t r);
        test_name       <= r.name;
        clk_en          <= r.en;
        omega_dt_packed <= r.omega;
        sr_field_packed <= r.field;
        target_x_packed <= r.tx;
        target_y_packed <= r.ty;
        beta_amplitude  <= r.beta;
        for (int c = 0; c < r.cycles; c++) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_checks(input int target);
        int waited;
        waited = 0;
        while (check_count < target && waited < CHECK_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (check_count < target) begin
            timeouts++;
            $display("Timeout: the checker stopped comparing before the last row settled");
        end
    endtask

    initial begin
        test_name       = "reset";
        arst_n          = 1'b0;
        clk_en          = 1'b0;
        omega_dt_packed = '0;
        sr_field_packed = '0;
        target_x_packed = '0;
        target_y_packed = '0;
        beta_amplitude  = '0;
        build_table();
        // Reset held for ten cycles
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
        end
        arst_n <= 1'b1;
        foreach (rows[r]) begin
            apply_row(rows[r]);
        end
        wait_checks(check_count + 3);
        $display("Checked %0d cycles: %0d mismatches, %0d timeouts",
                 check_count, error_count, timeouts);
        if (error_count == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
